/* verilog.f */
+incdir+design
design/buffer_pkg.sv
design/one_line_buffer.sv
design/burst_memory.sv
design/line_buffer_top.sv
testbench/line_buffer_assertions.sv
testbench/line_buffer_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= line_buffer_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
PASS_MSG  ?= === PASS ===
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -F -q -- "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/line_buffer_tb.sv */
`include "buffer_defs.svh"
`timescale 1ns/1ns

module line_buffer_tb import buffer_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int MEM_BYTES      = `MEM_WORDS * `BYTES_PER_WORD;

    logic         clk;
    logic         resetn;
    logic         req;
    logic         wr;
    access_size_t size;
    logic [31:0]  addr;
    view_t        wdata;
    logic         addr_ok;
    logic         data_ok;
    view_t        rdata;

    integer       seed;
    logic [7:0]   shadow [MEM_BYTES];

    // accepted requests still waiting for data_ok
    logic         pend_wr [$];
    logic [31:0]  pend_addr [$];
    view_t        pend_exp [$];
    access_size_t last_size;
    logic [31:0]  last_addr;

    line_buffer_top dut_i (
        .clk     (clk),
        .resetn  (resetn),
        .req     (req),
        .wr      (wr),
        .size    (size),
        .addr    (addr),
        .wdata   (wdata),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // store into the shadow if asked, then give back the whole aligned word
    function automatic view_t model_access(
        input logic         is_wr,
        input access_size_t sz,
        input logic [31:0]  a,
        input view_t        wd
    );
        int    base;
        int    first;
        int    count;
        view_t res;
        base  = int'(a) % MEM_BYTES;
        first = base % `BYTES_PER_WORD;
        base  = base - first;
        count = (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALF) ? 2 : `BYTES_PER_WORD;
        if (is_wr) begin
            for (int j = first; j < first + count; j++) begin
                shadow[base + j] = wd.bytes[j];
            end
        end
        for (int j = 0; j < `BYTES_PER_WORD; j++) begin
            res.bytes[j] = shadow[base + j];
        end
        return res;
    endfunction

    task automatic check_read_data(input view_t got, input view_t exp, input logic [31:0] a);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: read of %h gave %h, expected %h",
                $time, a, got.word, exp.word));
        end
    endtask

    task automatic check_completion(
        input access_size_t sz,
        input logic [31:0]  a,
        input bit           outstanding
    );
        if (!outstanding) begin
            stop_on_error($sformatf("data_ok came with no request outstanding (last was %s at %h)",
                sz.name(), a));
        end
    endtask

    // compare process
    always @(posedge clk) begin : compare
        view_t       expected;
        logic        was_wr;
        logic [31:0] was_addr;
        if (!resetn) begin
            if (req && addr_ok) begin
                expected = model_access(wr, size, addr, wdata);
                pend_wr.push_back(wr);
                pend_addr.push_back(addr);
                pend_exp.push_back(expected);
                last_size = size;
                last_addr = addr;
            end
            if (data_ok) begin
                check_completion(last_size, last_addr, pend_wr.size() > 0);
                if (pend_wr.size() > 0) begin
                    was_wr   = pend_wr.pop_front();
                    was_addr = pend_addr.pop_front();
                    expected = pend_exp.pop_front();
                    if (!was_wr) begin
                        check_read_data(rdata, expected, was_addr);
                    end
                end
            end
        end
    end

    // one request; latency counts cycles from acceptance to data_ok
    task automatic issue(
        input  logic         is_wr,
        input  access_size_t sz,
        input  logic [31:0]  a,
        input  view_t        wd,
        output int           latency
    );
        int waited;
        @(negedge clk);
        req    = 1'b1;
        wr     = is_wr;
        size   = sz;
        addr   = a;
        wdata  = wd;
        waited = 0;
        @(posedge clk);
        while (!addr_ok) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                stop_on_error("timeout waiting for addr_ok, request never accepted");
            end
            @(posedge clk);
        end
        latency = 0;
        if (!data_ok) begin
            // miss, so drop req while the bursts run
            @(negedge clk);
            req = 1'b0;
            @(posedge clk);
            latency = 1;
            while (!data_ok) begin
                latency++;
                if (latency > TIMEOUT_CYCLES) begin
                    stop_on_error("timeout waiting for data_ok after a miss");
                end
                @(posedge clk);
            end
        end
    endtask

    task automatic access_expect(
        input logic         is_wr,
        input access_size_t sz,
        input logic [31:0]  a,
        input logic [31:0]  value,
        input bit           hit_wanted
    );
        int    lat;
        view_t wd;
        wd.word = value;
        issue(is_wr, sz, a, wd, lat);
        if (hit_wanted != (lat == 0)) begin
            stop_on_error($sformatf("Fail at %0t: access to %h took %0d cycles, expected a %s",
                $time, a, lat, hit_wanted ? "hit" : "miss"));
        end
    endtask

    task automatic drive_idle();
        @(negedge clk);
        req = 1'b0;
    endtask

    initial begin : main
        int           lat;
        int           line_sel;
        int           word_sel;
        int           sz_pick;
        logic [31:0]  a;
        logic         is_wr;
        access_size_t sz;
        view_t        wd;
        seed   = 32'he2e2_b76c;
        resetn = 1'b1;
        req    = 1'b0;
        wr     = 1'b0;
        size   = SIZE_WORD;
        addr   = '0;
        wdata  = '0;
        foreach (shadow[i]) begin
            shadow[i] = 8'h00;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        resetn = 1'b0;

        // clean miss, then hits in the same line
        access_expect(1'b0, SIZE_WORD, 32'h104, 32'h0, 1'b0);
        access_expect(1'b0, SIZE_WORD, 32'h108, 32'h0, 1'b1);
        access_expect(1'b0, SIZE_WORD, 32'h13c, 32'h0, 1'b1);
        access_expect(1'b1, SIZE_WORD, 32'h110, 32'ha5a5_0001, 1'b1);
        access_expect(1'b0, SIZE_WORD, 32'h110, 32'h0, 1'b1);
        // sub-word stores
        access_expect(1'b1, SIZE_BYTE, 32'h111, 32'h0000_7e00, 1'b1);
        access_expect(1'b1, SIZE_BYTE, 32'h113, 32'h3c00_0000, 1'b1);
        access_expect(1'b1, SIZE_HALF, 32'h116, 32'hbeef_0000, 1'b1);
        access_expect(1'b0, SIZE_WORD, 32'h110, 32'h0, 1'b1);
        access_expect(1'b0, SIZE_WORD, 32'h114, 32'h0, 1'b1);
        // dirty miss writes back, then the data comes back from memory
        access_expect(1'b0, SIZE_WORD, 32'h304, 32'h0, 1'b0);
        access_expect(1'b0, SIZE_WORD, 32'h110, 32'h0, 1'b0);
        access_expect(1'b0, SIZE_WORD, 32'h114, 32'h0, 1'b1);
        // store miss merged into the refill
        access_expect(1'b1, SIZE_WORD, 32'h508, 32'h1122_3344, 1'b0);
        access_expect(1'b1, SIZE_WORD, 32'h504, 32'h5566_7788, 1'b1);
        access_expect(1'b0, SIZE_WORD, 32'h100, 32'h0, 1'b0);
        access_expect(1'b1, SIZE_HALF, 32'h50a, 32'hbeef_0000, 1'b0);
        access_expect(1'b0, SIZE_WORD, 32'h508, 32'h0, 1'b1);
        access_expect(1'b0, SIZE_WORD, 32'h504, 32'h0, 1'b1);
        access_expect(1'b0, SIZE_WORD, 32'h53c, 32'h0, 1'b1);

        // random mix over 8 lines spread across the memory
        for (int n = 0; n < 2000; n++) begin
            line_sel = {$random(seed)} % 8;
            word_sel = {$random(seed)} % `LINE_WORDS;
            sz_pick  = {$random(seed)} % 3;
            sz       = access_size_t'(sz_pick);
            a = line_sel * (MEM_BYTES / 8) + word_sel * `BYTES_PER_WORD;
            if (sz == SIZE_BYTE) begin
                a = a + ({$random(seed)} % 4);
            end else if (sz == SIZE_HALF) begin
                a = a + 2 * ({$random(seed)} % 2);
            end
            is_wr   = $random(seed) & 1;
            wd.word = $random(seed);
            issue(is_wr, sz, a, wd, lat);
            if (({$random(seed)} % 4) == 0) begin
                drive_idle();
            end
        end
        drive_idle();

        if (pend_wr.size() == 0 && dut_i.buffer_i.checks_i.failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* testbench/line_buffer_assertions.sv */
`include "buffer_defs.svh"
`timescale 1ns/1ns

module line_buffer_assertions (
    input logic        clk,
    input logic        resetn,
    input logic        req,
    input logic        addr_ok,
    input logic        data_ok,
    input logic        cbus_valid,
    input logic [31:0] cbus_addr,
    input logic        cbus_okay,
    input logic        cbus_last
);
    int unsigned failures = 0;

    // okays seen so far in the current burst
    logic [$clog2(`LINE_WORDS):0] okay_count;

    always_ff @(posedge clk) begin
        if (resetn) begin
            okay_count <= '0;
        end else if (cbus_last) begin
            okay_count <= '0;
        end else if (cbus_okay) begin
            okay_count <= okay_count + 1'b1;
        end
    end

    // an accepted miss makes the buffer busy on the next edge
    no_accept_while_busy: assert property (@(posedge clk) disable iff (resetn)
        (req && addr_ok && !data_ok) |=> (cbus_valid && !addr_ok))
    else begin
        failures++;
        $error("accepted miss did not start a burst with addr_ok low");
    end

    burst_request_stable: assert property (@(posedge clk) disable iff (resetn)
        (cbus_valid && !cbus_last) |=> (cbus_valid && $stable(cbus_addr)))
    else begin
        failures++;
        $error("cbus_valid or cbus_addr changed before cbus_last");
    end

    // last comes with the sixteenth okay and never elsewhere
    sixteen_beats: assert property (@(posedge clk) disable iff (resetn)
        cbus_okay |-> (cbus_last == (okay_count == `LINE_WORDS - 1)))
    else begin
        failures++;
        $error("burst did not end with cbus_last on beat %0d", `LINE_WORDS);
    end

endmodule

bind one_line_buffer line_buffer_assertions checks_i (
    .clk        (clk),
    .resetn     (resetn),
    .req        (req),
    .addr_ok    (addr_ok),
    .data_ok    (data_ok),
    .cbus_valid (cbus_valid),
    .cbus_addr  (cbus_addr),
    .cbus_okay  (cbus_okay),
    .cbus_last  (cbus_last)
);

/* design/line_buffer_top.sv */
`timescale 1ns/1ns

module line_buffer_top import buffer_pkg::*; #(
    parameter int MEM_LATENCY = 3
) (
    input  logic         clk,
    input  logic         resetn,

    input  logic         req,
    input  logic         wr,
    input  access_size_t size,
    input  logic [31:0]  addr,
    input  view_t        wdata,
    output logic         addr_ok,
    output logic         data_ok,
    output view_t        rdata
);
    // cache bus between buffer and memory
    logic        cbus_valid;
    logic        cbus_is_write;
    logic [31:0] cbus_addr;
    view_t       cbus_wdata;
    logic        cbus_okay;
    logic        cbus_last;
    view_t       cbus_rdata;

    one_line_buffer buffer_i (
        .clk           (clk),
        .resetn        (resetn),
        .req           (req),
        .wr            (wr),
        .size          (size),
        .addr          (addr),
        .wdata         (wdata),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .rdata         (rdata),
        .cbus_valid    (cbus_valid),
        .cbus_is_write (cbus_is_write),
        .cbus_addr     (cbus_addr),
        .cbus_wdata    (cbus_wdata),
        .cbus_okay     (cbus_okay),
        .cbus_last     (cbus_last),
        .cbus_rdata    (cbus_rdata)
    );

    burst_memory #(
        .MEM_LATENCY (MEM_LATENCY)
    ) memory_i (
        .clk           (clk),
        .resetn        (resetn),
        .cbus_valid    (cbus_valid),
        .cbus_is_write (cbus_is_write),
        .cbus_addr     (cbus_addr),
        .cbus_wdata    (cbus_wdata),
        .cbus_okay     (cbus_okay),
        .cbus_last     (cbus_last),
        .cbus_rdata    (cbus_rdata)
    );

endmodule

/* design/burst_memory.sv */
`include "buffer_defs.svh"
`timescale 1ns/1ns

module burst_memory import buffer_pkg::*; #(
    parameter int MEM_LATENCY = 3
) (
    input  logic        clk,
    input  logic        resetn,

    input  logic        cbus_valid,
    input  logic        cbus_is_write,
    input  logic [31:0] cbus_addr,
    input  view_t       cbus_wdata,
    output logic        cbus_okay,
    output logic        cbus_last,
    output view_t       cbus_rdata
);
    localparam int MEM_AW     = $clog2(`MEM_WORDS);
    localparam int LINE_BITS  = $clog2(`LINE_WORDS);
    localparam int DELAY_BITS = $clog2(MEM_LATENCY + 1);

    localparam logic [1:0] M_IDLE = 2'd0;
    localparam logic [1:0] M_BUSY = 2'd1;
    localparam logic [1:0] M_GAP  = 2'd2;

    // contents survive reset
    view_t mem [`MEM_WORDS] = '{default: '0};

    logic [1:0]            mstate;
    logic [DELAY_BITS-1:0] delay;
    logic [LINE_BITS-1:0]  beat;
    logic [MEM_AW-1:0]     base_q;
    logic                  write_q;
    logic [MEM_AW-1:0]     beat_addr;

    // wrap inside the line around the starting word
    assign beat_addr = {base_q[MEM_AW-1:LINE_BITS], base_q[LINE_BITS-1:0] + beat};

    always_ff @(posedge clk) begin
        if (resetn) begin
            mstate <= M_IDLE;
            delay  <= '0;
            beat   <= '0;
        end else begin
            case (mstate)
                M_IDLE: begin
                    if (cbus_valid) begin
                        mstate <= M_BUSY;
                        delay  <= DELAY_BITS'(MEM_LATENCY - 1);
                        beat   <= '0;
                    end
                end

                M_BUSY: begin
                    if (delay != '0) begin
                        delay <= delay - 1'b1;
                    end else begin
                        beat <= beat + 1'b1;
                        if (&beat) begin
                            mstate <= M_GAP;
                        end
                    end
                end

                // one dead cycle between bursts
                M_GAP: mstate <= M_IDLE;

                default: mstate <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mstate == M_IDLE && cbus_valid) begin
            base_q  <= cbus_addr[MEM_AW+1:2];
            write_q <= cbus_is_write;
        end
    end

    always_ff @(posedge clk) begin
        if (cbus_okay && write_q) begin
            mem[beat_addr] <= cbus_wdata;
        end
    end

    assign cbus_okay  = (mstate == M_BUSY) && (delay == '0);
    assign cbus_last  = cbus_okay && (&beat);
    assign cbus_rdata = mem[beat_addr];

endmodule

/* design/one_line_buffer.sv */
`include "buffer_defs.svh"
`timescale 1ns/1ns

module one_line_buffer import buffer_pkg::*; #(
    parameter int LINE_WORDS_P = `LINE_WORDS
) (
    input  logic         clk,
    input  logic         resetn,

    input  logic         req,
    input  logic         wr,
    input  access_size_t size,
    input  logic [31:0]  addr,
    input  view_t        wdata,
    output logic         addr_ok,
    output logic         data_ok,
    output view_t        rdata,

    output logic         cbus_valid,
    output logic         cbus_is_write,
    output logic [31:0]  cbus_addr,
    output view_t        cbus_wdata,
    input  logic         cbus_okay,
    input  logic         cbus_last,
    input  view_t        cbus_rdata
);
    localparam int STRB_W      = `BYTES_PER_WORD;
    localparam int ALIGN_BITS  = $clog2(`BYTES_PER_WORD);
    localparam int OFFSET_BITS = $clog2(LINE_WORDS_P);
    localparam int TAG_BITS    = 32 - OFFSET_BITS - ALIGN_BITS;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_READ  = 2'd1;
    localparam logic [1:0] S_WRITE = 2'd2;

    // byte enables for a size at a byte index
    function automatic logic [STRB_W-1:0] strobe_of(
        access_size_t sz,
        logic [ALIGN_BITS-1:0] idx
    );
        logic [STRB_W-1:0] strb;
        case (sz)
            SIZE_BYTE: strb = STRB_W'(1) << idx;
            SIZE_HALF: strb = STRB_W'(3) << idx;
            default:   strb = '1;
        endcase
        return strb;
    endfunction

    // replace enabled bytes of old_w by those of new_w
    function automatic view_t merge(
        view_t old_w,
        view_t new_w,
        logic [STRB_W-1:0] strb
    );
        view_t res;
        res = old_w;
        for (int j = 0; j < STRB_W; j++) begin
            if (strb[j]) begin
                res.bytes[j] = new_w.bytes[j];
            end
        end
        return res;
    endfunction

    // line store and its metadata
    view_t                  line_q [LINE_WORDS_P];
    logic [TAG_BITS-1:0]    tag_q;
    logic                   valid_q;
    logic                   dirty_q;

    logic [1:0]             state;
    logic [OFFSET_BITS-1:0] offset;

    // request saved on a miss
    logic                   saved_wr;
    access_size_t           saved_size;
    logic [TAG_BITS-1:0]    saved_tag;
    logic [OFFSET_BITS-1:0] saved_offset;
    logic [ALIGN_BITS-1:0]  saved_index;
    view_t                  saved_wdata;

    logic [TAG_BITS-1:0]    req_tag;
    logic [OFFSET_BITS-1:0] req_offset;
    logic [ALIGN_BITS-1:0]  req_index;
    logic [STRB_W-1:0]      req_strb;
    logic [STRB_W-1:0]      saved_strb;
    logic                   hit;
    logic                   offset_hit;
    view_t                  fill_word;

    assign req_tag    = addr[31 -: TAG_BITS];
    assign req_offset = addr[ALIGN_BITS +: OFFSET_BITS];
    assign req_index  = addr[ALIGN_BITS-1:0];

    assign req_strb   = strobe_of(size, req_index);
    assign saved_strb = strobe_of(saved_size, saved_index);

    assign hit        = valid_q && (tag_q == req_tag);
    assign offset_hit = (offset == saved_offset);

    // the pending store lands on its word as that word arrives
    assign fill_word = (saved_wr && offset_hit) ?
        merge(cbus_rdata, saved_wdata, saved_strb) : cbus_rdata;

    // controller
    always_ff @(posedge clk) begin
        if (resetn) begin
            state   <= S_IDLE;
            offset  <= '0;
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req && hit && wr) begin
                        dirty_q <= 1'b1;
                    end else if (req && !hit) begin
                        if (dirty_q) begin
                            state  <= S_WRITE;
                            offset <= '0;
                        end else begin
                            state  <= S_READ;
                            offset <= req_offset;
                        end
                    end
                end

                S_READ: begin
                    if (cbus_okay) begin
                        offset <= offset + 1'b1;
                    end
                    if (cbus_last) begin
                        state   <= S_IDLE;
                        valid_q <= 1'b1;
                        dirty_q <= saved_wr;
                    end
                end

                S_WRITE: begin
                    // refill starts at the requested word
                    if (cbus_last) begin
                        state  <= S_READ;
                        offset <= saved_offset;
                    end else if (cbus_okay) begin
                        offset <= offset + 1'b1;
                    end
                end

                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req && !hit) begin
            saved_wr     <= wr;
            saved_size   <= size;
            saved_tag    <= req_tag;
            saved_offset <= req_offset;
            saved_index  <= req_index;
            saved_wdata  <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req && hit && wr) begin
            line_q[req_offset] <= merge(line_q[req_offset], wdata, req_strb);
        end
        if (state == S_READ && cbus_okay) begin
            line_q[offset] <= fill_word;
        end
        if (state == S_READ && cbus_last) begin
            tag_q <= saved_tag;
        end
    end

    // processor side
    assign addr_ok = (state == S_IDLE);
    assign data_ok = (state == S_IDLE && req && hit) ||
                     (state == S_READ && cbus_okay && offset_hit);
    // forward the refill word straight through on a miss
    assign rdata   = (state == S_IDLE) ? line_q[req_offset] : cbus_rdata;

    // cache bus side
    assign cbus_valid    = (state != S_IDLE);
    assign cbus_is_write = (state == S_WRITE);
    assign cbus_wdata    = line_q[offset];
    // write-back from word 0 of the held line
    assign cbus_addr     = (state == S_WRITE) ?
        {tag_q, {OFFSET_BITS{1'b0}}, {ALIGN_BITS{1'b0}}} :
        {saved_tag, saved_offset, {ALIGN_BITS{1'b0}}};

endmodule

/* design/buffer_pkg.sv */
`include "buffer_defs.svh"

package buffer_pkg;

    // one bus word, seen whole or byte by byte
    typedef union packed {
        logic [`BYTES_PER_WORD-1:0][7:0] bytes;
        logic [`BITS_PER_WORD-1:0]       word;
    } view_t;

    // bytes touched by a request
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_t;

endpackage

/* design/buffer_defs.svh */
`ifndef BUFFER_DEFS_SVH
`define BUFFER_DEFS_SVH

// word geometry
`define BYTES_PER_WORD 4
`define BITS_PER_WORD  32

// words per line, also beats per burst
`define LINE_WORDS 16

// backing memory size in words
`define MEM_WORDS 1024

`endif
